/* rtl/controller_params.svh */
`ifndef CONTROLLER_PARAMS_SVH
`define CONTROLLER_PARAMS_SVH

// Major opcodes
`define OP_SPECIAL  6'b000000
`define OP_SPECIAL2 6'b011100
`define OP_REGIMM   6'b000001
`define OP_LW       6'b100011
`define OP_LH       6'b100001
`define OP_LB       6'b100000
`define OP_LUI      6'b001111
`define OP_SW       6'b101011
`define OP_SH       6'b101001
`define OP_SB       6'b101000
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BGTZ     6'b000111
`define OP_BLEZ     6'b000110
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_SEHB     6'b011111
`define OP_J        6'b000010
`define OP_JAL      6'b000011

// SPECIAL function codes
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_NOR      6'b100111
`define FN_XOR      6'b100110
`define FN_SLL      6'b000000
`define FN_SLLV     6'b000100
`define FN_SRL      6'b000010   // Also rotr, rs[0] set
`define FN_SRLV     6'b000110   // Also rotrv, shamt[0] set
`define FN_SLT      6'b101010
`define FN_MOVN     6'b001011
`define FN_MOVZ     6'b001010
`define FN_SRA      6'b000011
`define FN_SRAV     6'b000111
`define FN_SLTU     6'b101011
`define FN_MTHI     6'b010001
`define FN_MTLO     6'b010011
`define FN_MFHI     6'b010000
`define FN_MFLO     6'b010010
`define FN_JR       6'b001000

// SPECIAL2 function codes
`define FN_MUL      6'b000010
`define FN_MADD     6'b000000
`define FN_MSUB     6'b000100

// Sub-selectors in the rt and shamt fields
`define RT_BGEZ     5'b00001
`define RT_BLTZ     5'b00000
`define SA_SEH      5'b11000
`define SA_SEB      5'b10000

// Field encodings of the control bundle
`define DST_RT      2'd0
`define DST_RD      2'd1
`define DST_LINK    2'd2
`define HILO_NONE   2'd0
`define HILO_HI     2'd1
`define HILO_LO     2'd2
`define HILO_BOTH   2'd3
`define DT_WORD     2'd0
`define DT_HALF     2'd1
`define DT_BYTE     2'd2

// ALU operations, shared with the ALU
`define ALU_ADD     5'd0
`define ALU_SUB     5'd1
`define ALU_MULT    5'd2
`define ALU_AND     5'd3
`define ALU_OR      5'd4
`define ALU_NOR     5'd5
`define ALU_XOR     5'd6
`define ALU_SLL     5'd7
`define ALU_SRL     5'd8
`define ALU_ROTR    5'd9
`define ALU_SLT     5'd10
`define ALU_MOVN    5'd11
`define ALU_MOVZ    5'd12
`define ALU_SRA     5'd13
`define ALU_SLTU    5'd14
`define ALU_MTHI    5'd15
`define ALU_MTLO    5'd16
`define ALU_MFHI    5'd17
`define ALU_MFLO    5'd18
`define ALU_MUL     5'd19   // SPECIAL2 mul, low word to rd
`define ALU_MADD    5'd20
`define ALU_MSUB    5'd21
`define ALU_SEH     5'd22
`define ALU_SEB     5'd23
`define ALU_BGEZ    5'd24
`define ALU_BLTZ    5'd25
`define ALU_BEQ     5'd26
`define ALU_BNE     5'd27
`define ALU_BGTZ    5'd28
`define ALU_BLEZ    5'd29
`define ALU_LUI     5'd30
`define ALU_NONE    5'd31

`endif

/* rtl/ctrl_pkg.sv */
`include "controller_params.svh"

package ctrlPkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  regField_t;    // Register number or shift amount
    typedef logic [4:0]  aluOp_t;
    typedef logic [1:0]  hiLo_t;        // None, HI, LO or both
    typedef logic [1:0]  dataType_t;    // Word, half or byte
    typedef logic [1:0]  regDst_t;      // rt, rd or link

    // Instruction word split into R-format fields
    typedef struct packed {
        opcode_t   opcode;
        regField_t rs;
        regField_t rt;
        regField_t rd;
        regField_t shamt;
        funct_t    funct;
    } instrFields_t;

    // Datapath controls of one decoded instruction
    typedef struct packed {
        regDst_t   regDst;
        logic      aluSrc;      // Immediate as second ALU operand
        logic      aluSrc2;     // Shamt or jump target in place of rs
        logic      memToReg;
        logic      regWrite;
        hiLo_t     hiLoWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataType_t dataType;
        aluOp_t    aluOp;
        logic      signExtend;
        logic      index;       // Shift amount taken from the shamt field
    } ctrlBundle_t;

    // All enables low and no ALU operation
    localparam ctrlBundle_t NOP_BUNDLE = '{
        aluOp:   `ALU_NONE,
        default: '0
    };

endpackage

/* rtl/functDecoder.sv */
`include "controller_params.svh"

module functDecoder (
    input  ctrlPkg::opcode_t     opcode,
    input  ctrlPkg::regField_t   rs,
    input  ctrlPkg::regField_t   shamt,
    input  ctrlPkg::funct_t      funct,
    output ctrlPkg::ctrlBundle_t bundle,
    output logic                 hit
);
    import ctrlPkg::*;

    always_comb begin
        // Common to every R-format write into rd
        bundle          = NOP_BUNDLE;
        bundle.regDst   = `DST_RD;
        bundle.regWrite = 1'b1;
        hit             = 1'b1;

        if (opcode == `OP_SPECIAL) begin
            case (funct)
                `FN_ADD, `FN_ADDU: bundle.aluOp = `ALU_ADD;
                `FN_SUB:           bundle.aluOp = `ALU_SUB;
                `FN_MULT, `FN_MULTU: begin
                    bundle.aluOp     = `ALU_MULT;
                    bundle.hiLoWrite = `HILO_BOTH;
                end
                `FN_AND:  bundle.aluOp = `ALU_AND;
                `FN_OR:   bundle.aluOp = `ALU_OR;
                `FN_NOR:  bundle.aluOp = `ALU_NOR;
                `FN_XOR:  bundle.aluOp = `ALU_XOR;
                `FN_SLL: begin
                    bundle.aluOp   = `ALU_SLL;
                    bundle.aluSrc2 = 1'b1;
                    bundle.index   = 1'b1;
                end
                `FN_SLLV: bundle.aluOp = `ALU_SLL;
                `FN_SRL: begin
                    // rs[0] turns the logical shift into a rotate
                    bundle.aluOp   = rs[0] ? `ALU_ROTR : `ALU_SRL;
                    bundle.aluSrc2 = 1'b1;
                    bundle.index   = 1'b1;
                end
                `FN_SRLV: bundle.aluOp = shamt[0] ? `ALU_ROTR : `ALU_SRL;
                `FN_SRA: begin
                    bundle.aluOp   = `ALU_SRA;
                    bundle.aluSrc2 = 1'b1;
                    bundle.index   = 1'b1;
                end
                `FN_SRAV: bundle.aluOp = `ALU_SRA;
                `FN_SLT:  bundle.aluOp = `ALU_SLT;
                `FN_SLTU: bundle.aluOp = `ALU_SLTU;
                `FN_MOVN: bundle.aluOp = `ALU_MOVN;
                `FN_MOVZ: bundle.aluOp = `ALU_MOVZ;
                `FN_MTHI: begin
                    bundle.aluOp     = `ALU_MTHI;
                    bundle.hiLoWrite = `HILO_HI;
                end
                `FN_MTLO: begin
                    bundle.aluOp     = `ALU_MTLO;
                    bundle.hiLoWrite = `HILO_LO;
                end
                `FN_MFHI: bundle.aluOp = `ALU_MFHI;
                `FN_MFLO: bundle.aluOp = `ALU_MFLO;
                `FN_JR: begin
                    bundle.jump     = 1'b1;   // Target comes from rs
                    bundle.regWrite = 1'b0;
                end
                default: hit = 1'b0;
            endcase
        end else if (opcode == `OP_SPECIAL2) begin
            case (funct)
                `FN_MUL:  bundle.aluOp = `ALU_MUL;
                `FN_MADD: begin
                    bundle.aluOp     = `ALU_MADD;
                    bundle.hiLoWrite = `HILO_BOTH;   // Accumulates into HI/LO
                end
                `FN_MSUB: begin
                    bundle.aluOp     = `ALU_MSUB;
                    bundle.hiLoWrite = `HILO_BOTH;
                end
                default: hit = 1'b0;
            endcase
        end else begin
            hit = 1'b0;   // Not an R-format opcode
        end
    end

endmodule

/* rtl/immDecoder.sv */
`include "controller_params.svh"

module immDecoder (
    input  ctrlPkg::opcode_t     opcode,
    input  ctrlPkg::regField_t   rt,
    input  ctrlPkg::regField_t   shamt,
    output ctrlPkg::ctrlBundle_t bundle,
    output logic                 hit
);
    import ctrlPkg::*;

    dataType_t memSize;

    // Access size shared by loads and stores
    always_comb begin
        case (opcode)
            `OP_LH, `OP_SH: memSize = `DT_HALF;
            `OP_LB, `OP_SB: memSize = `DT_BYTE;
            default:        memSize = `DT_WORD;
        endcase
    end

    always_comb begin
        bundle = NOP_BUNDLE;
        hit    = 1'b1;

        case (opcode)
            `OP_LW, `OP_LH, `OP_LB: begin
                bundle.aluSrc   = 1'b1;
                bundle.memToReg = 1'b1;
                bundle.memRead  = 1'b1;
                bundle.regWrite = 1'b1;
                bundle.dataType = memSize;
                bundle.aluOp    = `ALU_ADD;   // Base plus offset
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                bundle.aluSrc   = 1'b1;
                bundle.memWrite = 1'b1;
                bundle.dataType = memSize;
                bundle.aluOp    = `ALU_ADD;
            end
            `OP_LUI: begin
                bundle.aluSrc   = 1'b1;
                bundle.regWrite = 1'b1;
                bundle.aluOp    = `ALU_LUI;
            end

            // Branch compare selected by opcode, or by rt for REGIMM
            `OP_REGIMM: begin
                bundle.branch = 1'b1;
                case (rt)
                    `RT_BGEZ: bundle.aluOp = `ALU_BGEZ;
                    `RT_BLTZ: bundle.aluOp = `ALU_BLTZ;
                    default:  hit = 1'b0;
                endcase
            end
            `OP_BEQ, `OP_BNE, `OP_BGTZ, `OP_BLEZ: begin
                bundle.branch = 1'b1;
                case (opcode)
                    `OP_BEQ: bundle.aluOp = `ALU_BEQ;
                    `OP_BNE: bundle.aluOp = `ALU_BNE;
                    `OP_BGTZ: bundle.aluOp = `ALU_BGTZ;
                    default: bundle.aluOp = `ALU_BLEZ;
                endcase
            end

            `OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_ORI,
            `OP_XORI, `OP_SLTI, `OP_SLTIU: begin
                bundle.aluSrc   = 1'b1;
                bundle.regWrite = 1'b1;
                bundle.regDst   = `DST_RT;
                case (opcode)
                    `OP_ANDI: bundle.aluOp = `ALU_AND;
                    `OP_ORI:  bundle.aluOp = `ALU_OR;
                    `OP_XORI: bundle.aluOp = `ALU_XOR;
                    `OP_SLTI: bundle.aluOp = `ALU_SLT;
                    `OP_SLTIU: bundle.aluOp = `ALU_SLTU;
                    default:  bundle.aluOp = `ALU_ADD;
                endcase
                // Logic immediates flagged for the extender
                bundle.signExtend = (opcode == `OP_ANDI) || (opcode == `OP_ORI)
                                    || (opcode == `OP_XORI);
            end

            `OP_SEHB: begin
                bundle.regDst   = `DST_RD;
                bundle.regWrite = 1'b1;
                case (shamt)
                    `SA_SEH: bundle.aluOp = `ALU_SEH;
                    `SA_SEB: bundle.aluOp = `ALU_SEB;
                    default: hit = 1'b0;
                endcase
            end

            `OP_J, `OP_JAL: begin
                bundle.jump    = 1'b1;
                bundle.aluSrc2 = 1'b1;
                if (opcode == `OP_JAL) begin
                    bundle.regWrite = 1'b1;   // Return address
                    bundle.regDst   = `DST_LINK;
                end
            end

            default: hit = 1'b0;
        endcase
    end

endmodule

/* rtl/decodeRegister.sv */
module decodeRegister (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 instrValid,
    input  logic                 flush,
    input  ctrlPkg::instr_t      instr,
    input  ctrlPkg::ctrlBundle_t functCtrl,
    input  ctrlPkg::ctrlBundle_t immCtrl,
    input  logic                 functHit,
    input  logic                 immHit,
    output logic                 ctrlValid,
    output ctrlPkg::ctrlBundle_t ctrl
);
    import ctrlPkg::*;

    ctrlBundle_t nextCtrl;

    // Flush and the all-zero word win over any decoder hit
    always_comb begin
        if (flush || instr == '0) begin
            nextCtrl = NOP_BUNDLE;
        end else if (functHit) begin
            nextCtrl = functCtrl;
        end else if (immHit) begin
            nextCtrl = immCtrl;
        end else begin
            nextCtrl = NOP_BUNDLE;   // Unknown encoding
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            ctrlValid <= 1'b0;
            ctrl      <= NOP_BUNDLE;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrl <= nextCtrl;   // Holds through idle cycles
            end
        end
    end

endmodule

/* rtl/controller.sv */
module controller (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 instrValid,
    input  ctrlPkg::instr_t      instr,
    input  logic                 flush,
    output logic                 ctrlValid,
    output ctrlPkg::ctrlBundle_t ctrl
);
    import ctrlPkg::*;

    instrFields_t fields;
    ctrlBundle_t  functCtrl;
    ctrlBundle_t  immCtrl;
    logic         functHit;
    logic         immHit;

    assign fields = instrFields_t'(instr);

    // R-format and SPECIAL2 group
    functDecoder uFunct (
        .opcode (fields.opcode),
        .rs     (fields.rs),
        .shamt  (fields.shamt),
        .funct  (fields.funct),
        .bundle (functCtrl),
        .hit    (functHit)
    );

    immDecoder uImm (
        .opcode (fields.opcode),
        .rt     (fields.rt),
        .shamt  (fields.shamt),
        .bundle (immCtrl),
        .hit    (immHit)
    );

    decodeRegister uReg (
        .Clock      (Clock),
        .reset      (reset),
        .instrValid (instrValid),
        .flush      (flush),
        .instr      (instr),
        .functCtrl  (functCtrl),
        .immCtrl    (immCtrl),
        .functHit   (functHit),
        .immHit     (immHit),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

endmodule

/* test/controller_sva.sv */
`include "controller_params.svh"

module controllerSva (
    input logic                 Clock,
    input logic                 reset,
    input logic                 instrValid,
    input ctrlPkg::instr_t      instr,
    input logic                 flush,
    input logic                 ctrlValid,
    input ctrlPkg::ctrlBundle_t ctrl
);
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    localparam ctrlBundle_t idleCtrl = '{aluOp: `ALU_NONE, default: '0};

    logic seenValid;   // First valid input taken
    int   assertErrors = 0;

    always_ff @(posedge Clock) begin
        if (reset) begin
            seenValid <= 1'b0;
        end else if (instrValid) begin
            seenValid <= 1'b1;
        end
    end

    idleAfterReset: assert property (@(posedge Clock) disable iff (reset)
        !seenValid |-> (!ctrlValid && ctrl == idleCtrl))
        else begin
            assertErrors++;
            $error("Output active before the first valid input");
        end

    // One output cycle per input cycle, one clock later
    validDelay: assert property (@(posedge Clock) disable iff (reset)
        ctrlValid == $past(instrValid))
        else begin
            assertErrors++;
            $error("ctrlValid does not follow instrValid by one cycle");
        end

    nopOnFlush: assert property (@(posedge Clock) disable iff (reset)
        (instrValid && (flush || instr == '0)) |=> (ctrl == idleCtrl))
        else begin
            assertErrors++;
            $error("Flushed or zero instruction did not give the nop bundle");
        end

    exclusiveCtrl: assert property (@(posedge Clock) disable iff (reset)
        !(ctrl.memRead && ctrl.memWrite) && !(ctrl.branch && ctrl.jump))
        else begin
            assertErrors++;
            $error("Conflicting memory or control-flow enables in ctrl");
        end

endmodule

bind controller controllerSva uSva (
    .Clock      (Clock),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .flush      (flush),
    .ctrlValid  (ctrlValid),
    .ctrl       (ctrl)
);

/* test/controllerTb.sv */
`include "controller_params.svh"

module controllerTb;
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    localparam int RandomCycles = 300;
    localparam int CycleLimit   = 500;   // Reset, directed list and random pass, with margin

    logic        Clock;
    logic        reset;
    logic        instrValid;
    logic        flush;
    instr_t      instr;
    logic        ctrlValid;
    ctrlBundle_t ctrl;

    instr_t      tableWord[$];
    ctrlBundle_t tableCtrl[$];
    ctrlBundle_t heldCtrl;       // Bundle the DUT should show now
    logic        expValid;
    int unsigned lcgState;
    int          valueErrors;
    int          checkCount;
    int          cycleCount;

    controller uut (
        .Clock      (Clock),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .flush      (flush),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic ctrlBundle_t nopCtrl();
        ctrlBundle_t b;
        b       = '0;
        b.aluOp = `ALU_NONE;
        return b;
    endfunction

    function automatic ctrlBundle_t rdWrite(aluOp_t op, hiLo_t hl, logic shiftImm);
        ctrlBundle_t b;
        b           = nopCtrl();
        b.regDst    = `DST_RD;
        b.regWrite  = 1'b1;
        b.aluOp     = op;
        b.hiLoWrite = hl;
        b.aluSrc2   = shiftImm;   // Immediate shifts read shamt
        b.index     = shiftImm;
        return b;
    endfunction

    function automatic ctrlBundle_t memCtrl(logic load, dataType_t dt);
        ctrlBundle_t b;
        b          = nopCtrl();
        b.aluSrc   = 1'b1;
        b.aluOp    = `ALU_ADD;
        b.dataType = dt;
        b.memToReg = load;
        b.memRead  = load;
        b.regWrite = load;
        b.memWrite = !load;
        return b;
    endfunction

    function automatic ctrlBundle_t branchCtrl(aluOp_t op);
        ctrlBundle_t b;
        b        = nopCtrl();
        b.branch = 1'b1;
        b.aluOp  = op;
        return b;
    endfunction

    function automatic ctrlBundle_t immAlu(aluOp_t op, logic logicImm);
        ctrlBundle_t b;
        b            = nopCtrl();
        b.aluSrc     = 1'b1;
        b.regWrite   = 1'b1;
        b.regDst     = `DST_RT;
        b.aluOp      = op;
        b.signExtend = logicImm;
        return b;
    endfunction

    function automatic instr_t rWord(opcode_t op, regField_t rs, regField_t shamt, funct_t fn);
        return {op, rs, 5'd9, 5'd10, shamt, fn};
    endfunction

    function automatic instr_t iWord(opcode_t op, regField_t rt);
        return {op, 5'd4, rt, 16'h8001};
    endfunction

    task automatic addEntry(instr_t word, ctrlBundle_t exp);
        tableWord.push_back(word);
        tableCtrl.push_back(exp);
    endtask

    task automatic addSpecial(funct_t fn, aluOp_t op, hiLo_t hl);
        addEntry(rWord(`OP_SPECIAL, 5'd2, 5'd0, fn), rdWrite(op, hl, 1'b0));
    endtask

    task automatic addShift(funct_t fn, regField_t rs, regField_t shamt, aluOp_t op, logic imm);
        addEntry(rWord(`OP_SPECIAL, rs, shamt, fn), rdWrite(op, `HILO_NONE, imm));
    endtask

    task automatic buildTable();
        ctrlBundle_t exp;
        addSpecial(`FN_ADD, `ALU_ADD, `HILO_NONE);
        addSpecial(`FN_ADDU, `ALU_ADD, `HILO_NONE);
        addSpecial(`FN_SUB, `ALU_SUB, `HILO_NONE);
        addSpecial(`FN_MULT, `ALU_MULT, `HILO_BOTH);
        addSpecial(`FN_MULTU, `ALU_MULT, `HILO_BOTH);
        addSpecial(`FN_AND, `ALU_AND, `HILO_NONE);
        addSpecial(`FN_OR, `ALU_OR, `HILO_NONE);
        addSpecial(`FN_NOR, `ALU_NOR, `HILO_NONE);
        addSpecial(`FN_XOR, `ALU_XOR, `HILO_NONE);
        addSpecial(`FN_SLT, `ALU_SLT, `HILO_NONE);
        addSpecial(`FN_SLTU, `ALU_SLTU, `HILO_NONE);
        addSpecial(`FN_MOVN, `ALU_MOVN, `HILO_NONE);
        addSpecial(`FN_MOVZ, `ALU_MOVZ, `HILO_NONE);
        addSpecial(`FN_MTHI, `ALU_MTHI, `HILO_HI);
        addSpecial(`FN_MTLO, `ALU_MTLO, `HILO_LO);
        addSpecial(`FN_MFHI, `ALU_MFHI, `HILO_NONE);
        addSpecial(`FN_MFLO, `ALU_MFLO, `HILO_NONE);
        addShift(`FN_SLL, 5'd0, 5'd6, `ALU_SLL, 1'b1);
        addShift(`FN_SLLV, 5'd2, 5'd0, `ALU_SLL, 1'b0);
        addShift(`FN_SRL, 5'd0, 5'd6, `ALU_SRL, 1'b1);
        addShift(`FN_SRL, 5'd1, 5'd6, `ALU_ROTR, 1'b1);     // rotr
        addShift(`FN_SRLV, 5'd2, 5'd0, `ALU_SRL, 1'b0);
        addShift(`FN_SRLV, 5'd2, 5'd1, `ALU_ROTR, 1'b0);    // rotrv
        addShift(`FN_SRA, 5'd0, 5'd6, `ALU_SRA, 1'b1);
        addShift(`FN_SRAV, 5'd2, 5'd0, `ALU_SRA, 1'b0);
        exp          = rdWrite(`ALU_NONE, `HILO_NONE, 1'b0);
        exp.regWrite = 1'b0;   // jr only redirects the PC
        exp.jump     = 1'b1;
        addEntry(rWord(`OP_SPECIAL, 5'd2, 5'd0, `FN_JR), exp);

        addEntry(rWord(`OP_SPECIAL2, 5'd2, 5'd0, `FN_MUL), rdWrite(`ALU_MUL, `HILO_NONE, 1'b0));
        addEntry(rWord(`OP_SPECIAL2, 5'd2, 5'd0, `FN_MADD), rdWrite(`ALU_MADD, `HILO_BOTH, 1'b0));
        addEntry(rWord(`OP_SPECIAL2, 5'd2, 5'd0, `FN_MSUB), rdWrite(`ALU_MSUB, `HILO_BOTH, 1'b0));

        addEntry(iWord(`OP_LW, 5'd7), memCtrl(1'b1, `DT_WORD));
        addEntry(iWord(`OP_LH, 5'd7), memCtrl(1'b1, `DT_HALF));
        addEntry(iWord(`OP_LB, 5'd7), memCtrl(1'b1, `DT_BYTE));
        addEntry(iWord(`OP_SW, 5'd7), memCtrl(1'b0, `DT_WORD));
        addEntry(iWord(`OP_SH, 5'd7), memCtrl(1'b0, `DT_HALF));
        addEntry(iWord(`OP_SB, 5'd7), memCtrl(1'b0, `DT_BYTE));
        exp          = immAlu(`ALU_LUI, 1'b0);
        addEntry(iWord(`OP_LUI, 5'd7), exp);

        addEntry(iWord(`OP_REGIMM, `RT_BGEZ), branchCtrl(`ALU_BGEZ));
        addEntry(iWord(`OP_REGIMM, `RT_BLTZ), branchCtrl(`ALU_BLTZ));
        addEntry(iWord(`OP_BEQ, 5'd7), branchCtrl(`ALU_BEQ));
        addEntry(iWord(`OP_BNE, 5'd7), branchCtrl(`ALU_BNE));
        addEntry(iWord(`OP_BGTZ, 5'd7), branchCtrl(`ALU_BGTZ));
        addEntry(iWord(`OP_BLEZ, 5'd7), branchCtrl(`ALU_BLEZ));

        addEntry(iWord(`OP_ADDI, 5'd7), immAlu(`ALU_ADD, 1'b0));
        addEntry(iWord(`OP_ADDIU, 5'd7), immAlu(`ALU_ADD, 1'b0));
        addEntry(iWord(`OP_ANDI, 5'd7), immAlu(`ALU_AND, 1'b1));
        addEntry(iWord(`OP_ORI, 5'd7), immAlu(`ALU_OR, 1'b1));
        addEntry(iWord(`OP_XORI, 5'd7), immAlu(`ALU_XOR, 1'b1));
        addEntry(iWord(`OP_SLTI, 5'd7), immAlu(`ALU_SLT, 1'b0));
        addEntry(iWord(`OP_SLTIU, 5'd7), immAlu(`ALU_SLTU, 1'b0));

        addEntry(rWord(`OP_SEHB, 5'd0, `SA_SEH, 6'b100000), rdWrite(`ALU_SEH, `HILO_NONE, 1'b0));
        addEntry(rWord(`OP_SEHB, 5'd0, `SA_SEB, 6'b100000), rdWrite(`ALU_SEB, `HILO_NONE, 1'b0));

        exp         = nopCtrl();
        exp.jump    = 1'b1;
        exp.aluSrc2 = 1'b1;
        addEntry({`OP_J, 26'h12345}, exp);
        exp.regWrite = 1'b1;
        exp.regDst   = `DST_LINK;
        addEntry({`OP_JAL, 26'h12345}, exp);

        // Encodings that neither decoder knows
        addEntry(rWord(`OP_SPECIAL, 5'd2, 5'd0, 6'b111111), nopCtrl());
        addEntry(rWord(`OP_SPECIAL2, 5'd2, 5'd0, 6'b111111), nopCtrl());
        addEntry(iWord(`OP_REGIMM, 5'd5), nopCtrl());
        addEntry(rWord(`OP_SEHB, 5'd0, 5'd3, 6'b100000), nopCtrl());
        addEntry({6'b111111, 26'h1}, nopCtrl());
    endtask

    task automatic checkField(string name, int expVal, int actVal);
        assert (expVal == actVal) else begin
            valueErrors++;
            $display("** Error at %0d ns: %s expected %0d, got %0d",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic compareBundle(ctrlBundle_t exp);
        checkField("ctrl.regDst", int'(exp.regDst), int'(ctrl.regDst));
        checkField("ctrl.aluSrc", int'(exp.aluSrc), int'(ctrl.aluSrc));
        checkField("ctrl.aluSrc2", int'(exp.aluSrc2), int'(ctrl.aluSrc2));
        checkField("ctrl.memToReg", int'(exp.memToReg), int'(ctrl.memToReg));
        checkField("ctrl.regWrite", int'(exp.regWrite), int'(ctrl.regWrite));
        checkField("ctrl.hiLoWrite", int'(exp.hiLoWrite), int'(ctrl.hiLoWrite));
        checkField("ctrl.memRead", int'(exp.memRead), int'(ctrl.memRead));
        checkField("ctrl.memWrite", int'(exp.memWrite), int'(ctrl.memWrite));
        checkField("ctrl.branch", int'(exp.branch), int'(ctrl.branch));
        checkField("ctrl.jump", int'(exp.jump), int'(ctrl.jump));
        checkField("ctrl.dataType", int'(exp.dataType), int'(ctrl.dataType));
        checkField("ctrl.aluOp", int'(exp.aluOp), int'(ctrl.aluOp));
        checkField("ctrl.signExtend", int'(exp.signExtend), int'(ctrl.signExtend));
        checkField("ctrl.index", int'(exp.index), int'(ctrl.index));
        checkCount++;
    endtask

    // Checks the previous cycle's result, then drives the next input
    task automatic driveCycle(logic valid, instr_t word, logic flushIn, ctrlBundle_t exp);
        @(posedge Clock);
        #1;
        checkField("ctrlValid", int'(expValid), int'(ctrlValid));
        compareBundle(heldCtrl);
        instrValid = valid;
        instr      = word;
        flush      = flushIn;
        expValid   = valid;
        if (valid) begin
            heldCtrl = (flushIn || word == '0) ? nopCtrl() : exp;
        end
    endtask

    initial begin
        int unsigned pick;
        int          idx;
        instr_t      word;
        reset       = 1'b1;
        instrValid  = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        heldCtrl    = nopCtrl();
        expValid    = 1'b0;
        lcgState    = 19;
        valueErrors = 0;
        checkCount  = 0;
        buildTable();
        repeat (5) @(posedge Clock);
        #1;
        reset = 1'b0;

        foreach (tableWord[i]) begin
            driveCycle(1'b1, tableWord[i], 1'b0, tableCtrl[i]);   // Back to back
        end
        driveCycle(1'b1, tableWord[0], 1'b1, tableCtrl[0]);   // Flushed add
        driveCycle(1'b1, '0, 1'b0, nopCtrl());
        driveCycle(1'b0, tableWord[5], 1'b0, tableCtrl[5]);   // Idle, ctrl must hold

        for (int i = 0; i < RandomCycles; i++) begin
            pick = nextRandom();
            idx  = int'(pick >> 16) % tableWord.size();
            pick = nextRandom();
            word = (pick[31:29] == 3'd0) ? '0 : tableWord[idx];
            driveCycle(pick[28:27] != 2'd0, word, pick[26:24] == 3'd0, tableCtrl[idx]);
        end
        driveCycle(1'b0, '0, 1'b0, nopCtrl());

        $display("%0d bundles checked, %0d value errors, %0d assertion errors",
                 checkCount, valueErrors, uut.uSva.assertErrors);
        if (valueErrors == 0 && uut.uSva.assertErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/functDecoder.sv
rtl/immDecoder.sv
rtl/decodeRegister.sv
rtl/controller.sv
test/controller_sva.sv
test/controllerTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = controllerTb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = ERRORS FOUND
PASS_MSG  = NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation stopped without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
